// File: flist.f
rename_pkg.sv
rename_free_list.sv
rename_table.sv
rename_stage.sv
rename_checker.sv
tb_rename.sv

// File: rename_checker.sv
`timescale 1ns/100ps

module rename_checker import rename_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  rename_req_t                 req_i,
    input  wb_t     [NUM_SCALAR_WB-1:0] wb_i,
    input  commit_t [NUM_COMMIT-1:0]    commit_i,
    input  recovery_t                   recovery_i,
    input  rename_rsp_t                 rsp_i,
    input  logic                        stall_i,
    input  logic                        out_of_checkpoints_i,
    output int                          error_count_o
);

    // Reference model state
    phreg_t                       map  [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic [NUM_ISA_REGISTERS-1:0] rdy  [NUM_CHECKPOINTS];
    phreg_t                       cmap [NUM_ISA_REGISTERS];
    phreg_t                       fq   [NUM_PHYS_REGISTERS];
    phreg_t                       fsave [NUM_CHECKPOINTS];   // Free head per checkpoint
    phreg_t                       fh, ft;
    checkpoint_ptr                head, tail;
    int                           num;
    rename_rsp_t                  exp_rsp;
    reg_t                         exp_rd;
    logic                         dup_seen;
    int                           errors = 0;

    assign error_count_o = errors;

    task automatic check_value(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    always @(posedge clk_i) begin
        logic          rec;
        logic          alloc;
        logic          take;
        checkpoint_ptr nxt;
        if (!rstn_i) begin
            for (int k = 0; k < NUM_CHECKPOINTS; k++) begin
                for (int a = 0; a < NUM_ISA_REGISTERS; a++) begin
                    map[k][a] = phreg_t'(a);
                end
                rdy[k] = '1;
            end
            for (int a = 0; a < NUM_ISA_REGISTERS; a++) begin
                cmap[a] = phreg_t'(a);
            end
            for (int i = 0; i < NUM_PHYS_REGISTERS; i++) begin
                fq[i] = phreg_t'(i + NUM_ISA_REGISTERS);
            end
            fh       = '0;
            ft       = phreg_t'(NUM_ISA_REGISTERS);
            head     = '0;
            tail     = '0;
            num      = 0;
            exp_rsp  = '0;
            exp_rd   = '0;
        end else begin
            rec   = recovery_i.do_recover | recovery_i.recover_commit;
            alloc = req_i.valid & req_i.write_rd & (req_i.rd != '0) & ~rec;
            take  = req_i.valid & req_i.do_checkpoint & ~rec & (num < NUM_CHECKPOINTS - 1);
            nxt   = head + checkpoint_ptr'(1);

            // Expected response from the working copy
            exp_rsp.valid = req_i.valid & ~rec;
            exp_rsp.src1  = map[head][req_i.rs1];
            exp_rsp.src2  = map[head][req_i.rs2];
            exp_rsp.rdy1  = rdy[head][req_i.rs1] | ~req_i.use_rs1;
            exp_rsp.rdy2  = rdy[head][req_i.rs2] | ~req_i.use_rs2;
            for (int i = 0; i < NUM_SCALAR_WB; i++) begin
                if (wb_i[i].ready && wb_i[i].vaddr == req_i.rs1 &&
                    map[head][req_i.rs1] == wb_i[i].paddr) begin
                    exp_rsp.rdy1 = 1'b1;
                end
                if (wb_i[i].ready && wb_i[i].vaddr == req_i.rs2 &&
                    map[head][req_i.rs2] == wb_i[i].paddr) begin
                    exp_rsp.rdy2 = 1'b1;
                end
            end
            exp_rsp.old_dst    = map[head][req_i.rd];
            exp_rsp.new_dst    = alloc ? fq[fh] : '0;
            exp_rsp.checkpoint = head;
            exp_rd             = req_i.rd;

            if (recovery_i.recover_commit) begin
                // Architectural state becomes the only copy
                for (int a = 0; a < NUM_ISA_REGISTERS; a++) begin
                    map[0][a] = cmap[a];
                end
                rdy[0] = '1;
                head   = '0;
                tail   = '0;
                num    = 0;
                fh     = ft - phreg_t'(NUM_ISA_REGISTERS);
            end else begin
                if (take) begin
                    for (int a = 0; a < NUM_ISA_REGISTERS; a++) begin
                        map[nxt][a] = map[head][a];
                    end
                    rdy[nxt] = rdy[head];
                end
                for (int i = 0; i < NUM_SCALAR_WB; i++) begin
                    for (int k = 0; k < NUM_CHECKPOINTS; k++) begin
                        if (wb_i[i].ready && map[k][wb_i[i].vaddr] == wb_i[i].paddr) begin
                            rdy[k][wb_i[i].vaddr] = 1'b1;
                        end
                    end
                end
                if (alloc) begin
                    map[head][req_i.rd] = fq[fh];      // Rename wins over a writeback
                    rdy[head][req_i.rd] = 1'b0;
                    if (take) begin
                        map[nxt][req_i.rd] = fq[fh];
                        rdy[nxt][req_i.rd] = 1'b0;
                    end
                    fh = fh + phreg_t'(1);
                end
                for (int c = 0; c < NUM_COMMIT; c++) begin
                    if (commit_i[c].write_dst && commit_i[c].old_dst != '0) begin
                        cmap[commit_i[c].old_dst] = commit_i[c].new_dst;
                        fq[ft] = commit_i[c].free_reg;
                        ft     = ft + phreg_t'(1);
                    end
                end
                if (recovery_i.do_recover) begin
                    num  = int'(checkpoint_ptr'(recovery_i.recover_checkpoint - tail));
                    head = recovery_i.recover_checkpoint;
                    fh   = fsave[recovery_i.recover_checkpoint];
                end else begin
                    if (take) begin
                        fsave[head] = fh;
                        head        = nxt;
                        num         = num + 1;
                    end
                    if (recovery_i.delete_checkpoint) begin
                        num = num - 1;
                    end
                end
                if (recovery_i.delete_checkpoint) begin
                    tail = tail + checkpoint_ptr'(1);
                end
            end
        end
    end

    // Outputs are compared away from the active clock edge
    always @(negedge clk_i) begin
        if (rstn_i) begin
            check_value("stall_o", int'((fh == ft) || (num == NUM_CHECKPOINTS - 1)),
                        int'(stall_i));
            check_value("out_of_checkpoints_o", int'(num == NUM_CHECKPOINTS - 1),
                        int'(out_of_checkpoints_i));
            check_value("rsp_o.valid", int'(exp_rsp.valid), int'(rsp_i.valid));
            if (exp_rsp.valid) begin
                check_value("rsp_o.src1", int'(exp_rsp.src1), int'(rsp_i.src1));
                check_value("rsp_o.rdy1", int'(exp_rsp.rdy1), int'(rsp_i.rdy1));
                check_value("rsp_o.src2", int'(exp_rsp.src2), int'(rsp_i.src2));
                check_value("rsp_o.rdy2", int'(exp_rsp.rdy2), int'(rsp_i.rdy2));
                check_value("rsp_o.new_dst", int'(exp_rsp.new_dst), int'(rsp_i.new_dst));
                check_value("rsp_o.old_dst", int'(exp_rsp.old_dst), int'(rsp_i.old_dst));
                check_value("rsp_o.checkpoint", int'(exp_rsp.checkpoint),
                            int'(rsp_i.checkpoint));
            end
            if (exp_rsp.valid && exp_rsp.new_dst != '0) begin
                dup_seen = 1'b0;
                for (int a = 0; a < NUM_ISA_REGISTERS; a++) begin
                    // Only the renamed rd may hold the new register
                    if (reg_t'(a) != exp_rd && map[head][a] == rsp_i.new_dst) begin
                        dup_seen = 1'b1;
                    end
                    if (cmap[a] == rsp_i.new_dst) begin
                        dup_seen = 1'b1;
                    end
                end
                if (dup_seen) begin
                    $display("Error at t=%0t: allocated a register that is still mapped",
                             $time);
                    errors++;
                end
            end
        end
    end

endmodule

// File: rename_free_list.sv
`timescale 1ns/100ps

module rename_free_list import rename_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     alloc_i,             // Pop the head entry
    input  commit_t [NUM_COMMIT-1:0] release_i,
    input  recovery_t                recovery_i,
    input  logic                     checkpoint_i,        // Checkpoint granted last cycle
    input  checkpoint_ptr            checkpoint_label_i,
    output phreg_t                   new_dst_o,
    output logic                     empty_o
);

    typedef logic [$clog2(NUM_PHYS_REGISTERS)-1:0] fl_ptr_t;

    phreg_t                queue_q [NUM_PHYS_REGISTERS];
    fl_ptr_t               saved_head_q [NUM_CHECKPOINTS];
    fl_ptr_t               head_q, head_d;
    fl_ptr_t               tail_q, tail_d;
    fl_ptr_t               restore_head;
    fl_ptr_t               wr_ptr [NUM_COMMIT];
    logic [NUM_COMMIT-1:0] push_en;

    // Released registers are packed at the tail in port order
    always_comb begin
        tail_d = tail_q;
        for (int i = 0; i < NUM_COMMIT; i++) begin
            push_en[i] = release_i[i].write_dst & (release_i[i].old_dst != '0) &
                         ~recovery_i.recover_commit;
            wr_ptr[i]  = tail_d;
            tail_d     = tail_d + fl_ptr_t'(push_en[i]);
        end
    end

    // The snapshot is written one cycle late, so bypass it for an immediate recover
    assign restore_head = (checkpoint_i && checkpoint_label_i == recovery_i.recover_checkpoint) ?
                          head_q : saved_head_q[recovery_i.recover_checkpoint];

    always_comb begin
        head_d = head_q;
        if (recovery_i.recover_commit) begin
            // Only the committed mappings stay allocated
            head_d = tail_q - fl_ptr_t'(NUM_ISA_REGISTERS);
        end else if (recovery_i.do_recover) begin
            head_d = restore_head;
        end else if (alloc_i) begin
            head_d = head_q + fl_ptr_t'(1);
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= fl_ptr_t'(NUM_ISA_REGISTERS);     // Entries 0..31 hold p32..p63
            for (int i = 0; i < NUM_PHYS_REGISTERS; i++) begin
                queue_q[i] <= phreg_t'(i + NUM_ISA_REGISTERS);
            end
        end else begin
            head_q <= head_d;
            tail_q <= tail_d;
            for (int i = 0; i < NUM_COMMIT; i++) begin
                if (push_en[i]) begin
                    queue_q[wr_ptr[i]] <= release_i[i].free_reg;
                end
            end
        end
    end

    // Head already includes the pop of the checkpointing instruction
    always_ff @(posedge clk_i) begin
        if (checkpoint_i) begin
            saved_head_q[checkpoint_label_i] <= head_q;
        end
    end

    assign new_dst_o = queue_q[head_q];
    assign empty_o   = (head_q == tail_q);

endmodule

// File: rename_pkg.sv
package rename_pkg;

    localparam int NUM_ISA_REGISTERS  = 32;
    localparam int NUM_PHYS_REGISTERS = 64;
    localparam int NUM_CHECKPOINTS    = 4;
    localparam int NUM_SCALAR_WB      = 2;
    localparam int NUM_COMMIT         = 2;

    typedef logic [$clog2(NUM_ISA_REGISTERS)-1:0]  reg_t;
    typedef logic [$clog2(NUM_PHYS_REGISTERS)-1:0] phreg_t;
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0]    checkpoint_ptr;

    // One bit wider than the label so a full ring can be counted
    typedef logic [$clog2(NUM_CHECKPOINTS):0]      checkpoint_cnt_t;

    typedef struct packed {
        logic valid;
        reg_t rs1;
        reg_t rs2;
        reg_t rd;
        logic use_rs1;
        logic use_rs2;
        logic write_rd;
        logic do_checkpoint;    // Snapshot taken after this rename
    } rename_req_t;

    typedef struct packed {
        logic          valid;
        phreg_t        src1;
        logic          rdy1;
        phreg_t        src2;
        logic          rdy2;
        phreg_t        new_dst;
        phreg_t        old_dst;
        checkpoint_ptr checkpoint;
    } rename_rsp_t;

    typedef struct packed {
        logic   ready;
        reg_t   vaddr;
        phreg_t paddr;
    } wb_t;

    typedef struct packed {
        logic   write_dst;
        reg_t   old_dst;        // Architectural destination
        phreg_t new_dst;
        phreg_t free_reg;       // Previous mapping, goes back to the free list
    } commit_t;

    typedef struct packed {
        logic          recover_commit;
        logic          do_recover;
        logic          delete_checkpoint;
        checkpoint_ptr recover_checkpoint;
    } recovery_t;

endpackage

// File: rename_stage.sv
`timescale 1ns/100ps

module rename_stage import rename_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  rename_req_t                 req_i,
    input  wb_t     [NUM_SCALAR_WB-1:0] wb_i,
    input  commit_t [NUM_COMMIT-1:0]    commit_i,
    input  recovery_t                   recovery_i,
    output rename_rsp_t                 rsp_o,
    output logic                        stall_o,
    output logic                        out_of_checkpoints_o
);

    logic          recovering;
    logic          alloc;
    logic          empty;
    logic          valid_q;
    phreg_t        new_dst;
    phreg_t        new_dst_q;
    phreg_t        src1, src2, old_dst;
    logic          rdy1, rdy2;
    checkpoint_ptr checkpoint;
    logic          checkpoint_taken;

    assign recovering = recovery_i.do_recover | recovery_i.recover_commit;

    // x0 never gets a physical register
    assign alloc   = req_i.valid & req_i.write_rd & (req_i.rd != '0) & ~recovering;
    assign stall_o = empty | out_of_checkpoints_o;

    rename_free_list u_free_list (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .alloc_i            (alloc),
        .release_i          (commit_i),
        .recovery_i         (recovery_i),
        .checkpoint_i       (checkpoint_taken),
        .checkpoint_label_i (checkpoint),
        .new_dst_o          (new_dst),
        .empty_o            (empty)
    );

    rename_table u_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .write_dst_i          (alloc),
        .new_dst_i            (new_dst),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recovery_i           (recovery_i),
        .src1_o               (src1),
        .rdy1_o               (rdy1),
        .src2_o               (src2),
        .rdy2_o               (rdy2),
        .old_dst_o            (old_dst),
        .checkpoint_o         (checkpoint),
        .checkpoint_taken_o   (checkpoint_taken),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid & ~recovering;
        end
    end

    // Non-allocating instructions report p0 as destination
    always_ff @(posedge clk_i) begin
        new_dst_q <= alloc ? new_dst : '0;
    end

    always_comb begin
        rsp_o.valid      = valid_q;
        rsp_o.src1       = src1;
        rsp_o.rdy1       = rdy1;
        rsp_o.src2       = src2;
        rsp_o.rdy2       = rdy2;
        rsp_o.new_dst    = new_dst_q;
        rsp_o.old_dst    = old_dst;
        rsp_o.checkpoint = checkpoint;
    end

endmodule

// File: rename_table.sv
`timescale 1ns/100ps

module rename_table import rename_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  rename_req_t                 req_i,
    input  logic                        write_dst_i,          // Rename rd this cycle
    input  phreg_t                      new_dst_i,

    input  wb_t     [NUM_SCALAR_WB-1:0] wb_i,
    input  commit_t [NUM_COMMIT-1:0]    commit_i,
    input  recovery_t                   recovery_i,

    output phreg_t                      src1_o,
    output logic                        rdy1_o,
    output phreg_t                      src2_o,
    output logic                        rdy2_o,
    output phreg_t                      old_dst_o,

    output checkpoint_ptr               checkpoint_o,
    output logic                        checkpoint_taken_o,
    output logic                        out_of_checkpoints_o
);

    // Per-slot copies of the speculative map and its ready bits
    phreg_t                       map_q    [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t                       map_d    [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic [NUM_ISA_REGISTERS-1:0] rdy_q    [NUM_CHECKPOINTS];
    logic [NUM_ISA_REGISTERS-1:0] rdy_d    [NUM_CHECKPOINTS];
    phreg_t                       commit_q [NUM_ISA_REGISTERS];
    phreg_t                       commit_d [NUM_ISA_REGISTERS];

    checkpoint_ptr   head_q, head_d;      // Working copy
    checkpoint_ptr   tail_q, tail_d;      // Oldest live checkpoint
    checkpoint_cnt_t num_q, num_d;
    checkpoint_ptr   next_slot;

    logic                     checkpoint_enable;
    logic                     read_enable;
    logic [NUM_COMMIT-1:0]    commit_enable;
    logic [NUM_SCALAR_WB-1:0] fwd1;
    logic [NUM_SCALAR_WB-1:0] fwd2;

    assign next_slot   = head_q + checkpoint_ptr'(1);
    assign read_enable = ~recovery_i.do_recover & ~recovery_i.recover_commit;

    // A free slot must remain for the new working copy
    assign checkpoint_enable = req_i.valid & req_i.do_checkpoint & read_enable &
                               (num_q < checkpoint_cnt_t'(NUM_CHECKPOINTS - 1));

    always_comb begin
        for (int c = 0; c < NUM_COMMIT; c++) begin
            commit_enable[c] = commit_i[c].write_dst & (commit_i[c].old_dst != '0) &
                               ~recovery_i.recover_commit;
        end
    end

    always_comb begin
        checkpoint_ptr src_slot;
        logic          renamed;

        map_d    = map_q;
        rdy_d    = rdy_q;
        commit_d = commit_q;
        head_d   = head_q;
        tail_d   = tail_q;
        num_d    = num_q;
        src_slot = head_q;
        renamed  = 1'b0;

        if (recovery_i.recover_commit) begin
            // Exception: rebuild slot 0 from the architectural state
            map_d[0] = commit_q;
            rdy_d[0] = '1;
            head_d   = '0;
            tail_d   = '0;
            num_d    = '0;
        end else begin
            tail_d = tail_q + checkpoint_ptr'(recovery_i.delete_checkpoint);

            if (recovery_i.do_recover) begin
                head_d = recovery_i.recover_checkpoint;
                // Live checkpoints are the slots from tail up to the restored head
                num_d  = checkpoint_cnt_t'(checkpoint_ptr'(recovery_i.recover_checkpoint - tail_q));
            end else begin
                num_d = num_q + checkpoint_cnt_t'(checkpoint_enable)
                              - checkpoint_cnt_t'(recovery_i.delete_checkpoint);

                if (checkpoint_enable) begin
                    map_d[next_slot] = map_q[head_q];
                    rdy_d[next_slot] = rdy_q[head_q];
                    head_d           = next_slot;
                end

                // Rename lands in the frozen slot and in the new working copy
                if (write_dst_i) begin
                    map_d[head_q][req_i.rd] = new_dst_i;
                    rdy_d[head_q][req_i.rd] = 1'b0;
                    if (checkpoint_enable) begin
                        map_d[next_slot][req_i.rd] = new_dst_i;
                        rdy_d[next_slot][req_i.rd] = 1'b0;
                    end
                end
            end

            // Later port wins when both commit the same register
            for (int c = 0; c < NUM_COMMIT; c++) begin
                if (commit_enable[c]) begin
                    commit_d[commit_i[c].old_dst] = commit_i[c].new_dst;
                end
            end

            for (int i = 0; i < NUM_SCALAR_WB; i++) begin
                if (wb_i[i].ready) begin
                    for (int j = 0; j < NUM_CHECKPOINTS; j++) begin
                        // The new copy is still being filled from the head slot
                        src_slot = (checkpoint_enable && checkpoint_ptr'(j) == next_slot) ?
                                   head_q : checkpoint_ptr'(j);
                        renamed  = write_dst_i && (wb_i[i].vaddr == req_i.rd) &&
                                   ((checkpoint_ptr'(j) == head_q) ||
                                    (checkpoint_enable && checkpoint_ptr'(j) == next_slot));
                        if (map_q[src_slot][wb_i[i].vaddr] == wb_i[i].paddr && !renamed) begin
                            rdy_d[j][wb_i[i].vaddr] = 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Same-cycle writeback bypass for the sources being read
    always_comb begin
        for (int i = 0; i < NUM_SCALAR_WB; i++) begin
            fwd1[i] = wb_i[i].ready && (wb_i[i].vaddr == req_i.rs1) &&
                      (map_q[head_q][req_i.rs1] == wb_i[i].paddr);
            fwd2[i] = wb_i[i].ready && (wb_i[i].vaddr == req_i.rs2) &&
                      (map_q[head_q][req_i.rs2] == wb_i[i].paddr);
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            src1_o             <= '0;
            rdy1_o             <= 1'b0;
            src2_o             <= '0;
            rdy2_o             <= 1'b0;
            old_dst_o          <= '0;
            checkpoint_o       <= '0;
            checkpoint_taken_o <= 1'b0;
        end else if (recovery_i.recover_commit) begin
            src1_o             <= '0;
            rdy1_o             <= 1'b0;
            src2_o             <= '0;
            rdy2_o             <= 1'b0;
            old_dst_o          <= '0;
            checkpoint_o       <= '0;
            checkpoint_taken_o <= 1'b0;
        end else begin
            if (read_enable) begin
                src1_o    <= map_q[head_q][req_i.rs1];
                rdy1_o    <= rdy_q[head_q][req_i.rs1] | (|fwd1) | ~req_i.use_rs1;
                src2_o    <= map_q[head_q][req_i.rs2];
                rdy2_o    <= rdy_q[head_q][req_i.rs2] | (|fwd2) | ~req_i.use_rs2;
                old_dst_o <= map_q[head_q][req_i.rd];
            end
            checkpoint_o       <= head_q;      // Frozen slot when a checkpoint is taken
            checkpoint_taken_o <= checkpoint_enable;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < NUM_CHECKPOINTS; k++) begin
                for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                    map_q[k][j] <= phreg_t'(j);    // Identity mapping
                end
                rdy_q[k] <= '1;
            end
            for (int j = 0; j < NUM_ISA_REGISTERS; j++) begin
                commit_q[j] <= phreg_t'(j);
            end
            head_q <= '0;
            tail_q <= '0;
            num_q  <= '0;
        end else begin
            map_q    <= map_d;
            rdy_q    <= rdy_d;
            commit_q <= commit_d;
            head_q   <= head_d;
            tail_q   <= tail_d;
            num_q    <= num_d;
        end
    end

    assign out_of_checkpoints_o = (num_q == checkpoint_cnt_t'(NUM_CHECKPOINTS - 1));

endmodule

// File: run_sim.sh
#!/bin/bash
# Builds the rename stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_rename -o tb_rename
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_rename > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator returned status $status"
    exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1

// File: tb_rename.sv
`timescale 1ns/100ps

module tb_rename import rename_pkg::*; ();

    localparam int NUM_CYCLES     = 2000;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    logic                        clk_i;
    logic                        rstn_i;
    rename_req_t                 req_i;
    wb_t     [NUM_SCALAR_WB-1:0] wb_i;
    commit_t [NUM_COMMIT-1:0]    commit_i;
    recovery_t                   recovery_i;
    rename_rsp_t                 rsp_o;
    logic                        stall_o;
    logic                        out_of_checkpoints_o;

    // Values planned at the falling edge, applied at the next rising edge
    rename_req_t                 req_n;
    wb_t     [NUM_SCALAR_WB-1:0] wb_n;
    commit_t [NUM_COMMIT-1:0]    commit_n;
    recovery_t                   rec_n;
    rename_req_t                 prev_req;

    integer seed;
    int     cycle_cnt;
    int     seq_cnt;
    int     error_count;

    // Renamed instructions still in flight, oldest first
    int            fl_seq [$];
    reg_t          fl_rd  [$];
    phreg_t        fl_new [$];
    phreg_t        fl_old [$];
    // Live checkpoints, oldest first
    int            cp_seq   [$];
    checkpoint_ptr cp_label [$];

    rename_stage DUT (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recovery_i           (recovery_i),
        .rsp_o                (rsp_o),
        .stall_o              (stall_o),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

    rename_checker u_checker (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recovery_i           (recovery_i),
        .rsp_i                (rsp_o),
        .stall_i              (stall_o),
        .out_of_checkpoints_i (out_of_checkpoints_o),
        .error_count_o        (error_count)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        req_i      <= req_n;
        wb_i       <= wb_n;
        commit_i   <= commit_n;
        recovery_i <= rec_n;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Response of last cycle's request feeds the in-flight bookkeeping
    task automatic record_response();
        if (rsp_o.valid) begin
            seq_cnt++;
            if (rsp_o.new_dst != '0) begin
                fl_seq.push_back(seq_cnt);
                fl_rd.push_back(prev_req.rd);
                fl_new.push_back(rsp_o.new_dst);
                fl_old.push_back(rsp_o.old_dst);
            end
            if (prev_req.do_checkpoint) begin
                cp_seq.push_back(seq_cnt);
                cp_label.push_back(rsp_o.checkpoint);
            end
        end
        prev_req = req_i;
    endtask

    task automatic drop_inflight_after(input int last_seq);
        while (fl_seq.size() > 0 && fl_seq[fl_seq.size()-1] > last_seq) begin
            void'(fl_seq.pop_back());
            void'(fl_rd.pop_back());
            void'(fl_new.pop_back());
            void'(fl_old.pop_back());
        end
    endtask

    task automatic plan_inputs();
        int r;
        int k;
        req_n    = '0;
        wb_n     = '0;
        commit_n = '0;
        rec_n    = '0;
        r = $unsigned($random(seed)) % 100;
        // Recoveries only when no request is in flight
        if (!req_i.valid && r < 1) begin
            rec_n.recover_commit = 1'b1;
            drop_inflight_after(-1);
            cp_seq.delete();
            cp_label.delete();
        end else if (!req_i.valid && r < 5 && cp_seq.size() > 0) begin
            k = $unsigned($random(seed)) % cp_seq.size();
            rec_n.do_recover         = 1'b1;
            rec_n.recover_checkpoint = cp_label[k];
            drop_inflight_after(cp_seq[k]);
            while (cp_seq.size() > k) begin
                void'(cp_seq.pop_back());
                void'(cp_label.pop_back());
            end
        end else begin
            if (r >= 95 && cp_seq.size() > 0) begin
                rec_n.delete_checkpoint = 1'b1;
                void'(cp_seq.pop_front());
                void'(cp_label.pop_front());
            end
            // In-order commit, never past the oldest live checkpoint
            for (int c = 0; c < NUM_COMMIT; c++) begin
                if (fl_seq.size() > 0 && (cp_seq.size() == 0 || fl_seq[0] <= cp_seq[0]) &&
                    ($unsigned($random(seed)) % 2 == 0)) begin
                    commit_n[c].write_dst = 1'b1;
                    commit_n[c].old_dst   = fl_rd.pop_front();
                    commit_n[c].new_dst   = fl_new.pop_front();
                    commit_n[c].free_reg  = fl_old.pop_front();
                    void'(fl_seq.pop_front());
                end
            end
            for (int i = 0; i < NUM_SCALAR_WB; i++) begin
                k = $unsigned($random(seed)) % 4;
                if (k < 2 && fl_seq.size() > 0) begin
                    k = $unsigned($random(seed)) % fl_seq.size();
                    wb_n[i].ready = 1'b1;
                    wb_n[i].vaddr = fl_rd[k];
                    wb_n[i].paddr = fl_new[k];
                end else if (k == 2) begin
                    wb_n[i].ready = 1'b1;       // Mostly stale, rarely matches
                    wb_n[i].vaddr = reg_t'($random(seed));
                    wb_n[i].paddr = phreg_t'($random(seed));
                end
            end
            // A pending rename may use the last free register or checkpoint
            k = $unsigned($random(seed)) % 4;
            if (!stall_o && !(req_i.valid && (req_i.write_rd || req_i.do_checkpoint)) &&
                k != 0) begin
                req_n.valid         = 1'b1;
                req_n.rs1           = reg_t'($random(seed));
                req_n.rs2           = reg_t'($random(seed));
                req_n.rd            = reg_t'($random(seed));
                req_n.use_rs1       = 1'($random(seed));
                req_n.use_rs2       = 1'($random(seed));
                req_n.write_rd      = ($unsigned($random(seed)) % 4 != 0);
                req_n.do_checkpoint = ($unsigned($random(seed)) % 8 == 0);
            end
        end
    endtask

    initial begin
        seed       = 32'he4fd;
        cycle_cnt  = 0;
        seq_cnt    = 0;
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        req_i      = '0;
        wb_i       = '0;
        commit_i   = '0;
        recovery_i = '0;
        req_n      = '0;
        wb_n       = '0;
        commit_n   = '0;
        rec_n      = '0;
        prev_req   = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(negedge clk_i);
            record_response();
            plan_inputs();
        end
        @(negedge clk_i);
        req_n    = '0;
        wb_n     = '0;
        commit_n = '0;
        rec_n    = '0;
        repeat (3) @(negedge clk_i);     // Drain the last response
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
